/* design/alu.sv */
`timescale 1ns/1ns

module alu import uart_alu_pkg::*; (
    input  alu_command_t i_command,
    output data_t        o_result
);

    data_t      operand_a;
    data_t      operand_b;
    bit_index_t shift_amount;

    assign operand_a = i_command.operand_a;
    assign operand_b = i_command.operand_b;

    // Only the low bits of B count for shifts
    assign shift_amount = operand_b[$bits(bit_index_t)-1:0];

    always_comb begin
        case (i_command.opcode)
            ADD: begin
                o_result = operand_a + operand_b;
            end
            SUB: begin
                o_result = operand_a - operand_b;
            end
            AND: begin
                o_result = operand_a & operand_b;
            end
            OR: begin
                o_result = operand_a | operand_b;
            end
            XOR: begin
                o_result = operand_a ^ operand_b;
            end
            NOR: begin
                o_result = ~(operand_a | operand_b);
            end
            SRL: begin
                o_result = operand_a >> shift_amount;
            end
            SRA: begin
                // Sign fill from bit 7 of A
                o_result = data_t'($signed(operand_a) >>> shift_amount);
            end
            default: begin
                o_result = '0;
            end
        endcase
    end

endmodule

/* design/alu_command_sequencer.sv */
`timescale 1ns/1ns

module alu_command_sequencer import uart_alu_pkg::*; (
    input  logic         i_clock,
    input  logic         i_reset,
    // Receive FIFO side
    input  data_t        i_rx_data,
    input  logic         i_rx_empty,
    output logic         o_rx_read,
    // ALU side
    output alu_command_t o_command,
    input  data_t        i_result,
    // Transmit FIFO side
    input  logic         i_tx_full,
    output data_t        o_tx_data,
    output logic         o_tx_write
);

    seq_state_e   state;
    alu_command_t command;
    data_t        result_reg;
    logic         tx_write_reg;
    logic         result_take;

    ////////////////////////////////////////////////////////////////////////////
    // Strobes and outputs
    ////////////////////////////////////////////////////////////////////////////

    // Pop in any GET state as soon as a byte is waiting
    assign o_rx_read   = (state != WRITE_RESULT) && !i_rx_empty;
    assign result_take = (state == WRITE_RESULT) && !i_tx_full;

    assign o_command  = command;
    assign o_tx_data  = result_reg;
    assign o_tx_write = tx_write_reg;

    ////////////////////////////////////////////////////////////////////////////
    // Command FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clock or posedge i_reset) begin
        if (i_reset) begin
            state        <= GET_OPCODE;
            command      <= '0;
            tx_write_reg <= 1'b0;
        end else begin
            tx_write_reg <= 1'b0;
            case (state)
                GET_OPCODE: begin
                    if (o_rx_read) begin
                        // Top two bits of the opcode byte are ignored
                        command.opcode <= i_rx_data[OPCODE_WIDTH-1:0];
                        state          <= GET_OPERAND_A;
                    end
                end
                GET_OPERAND_A: begin
                    if (o_rx_read) begin
                        command.operand_a <= i_rx_data;
                        state             <= GET_OPERAND_B;
                    end
                end
                GET_OPERAND_B: begin
                    if (o_rx_read) begin
                        command.operand_b <= i_rx_data;
                        state             <= WRITE_RESULT;
                    end
                end
                WRITE_RESULT: begin
                    // Wait here while the transmit FIFO is full
                    if (result_take) begin
                        tx_write_reg <= 1'b1;
                        state        <= GET_OPCODE;
                    end
                end
                default: state <= GET_OPCODE;
            endcase
        end
    end

    // Result goes out with the write strobe on the following cycle
    always_ff @(posedge i_clock) begin
        if (result_take) begin
            result_reg <= i_result;
        end
    end

endmodule

/* design/byte_fifo.sv */
`timescale 1ns/1ns

module byte_fifo import uart_alu_pkg::*; #(
    parameter int DEPTH = FIFO_DEPTH
) (
    input  logic  i_clock,
    input  logic  i_reset,
    input  logic  i_write,
    input  data_t i_data,
    input  logic  i_read,
    output data_t o_data,
    output logic  o_empty,
    output logic  o_full
);

    typedef logic [$clog2(DEPTH)-1:0]   ptr_t;
    typedef logic [$clog2(DEPTH+1)-1:0] count_t;

    data_t  mem [DEPTH];
    ptr_t   read_ptr;
    ptr_t   write_ptr;
    count_t count;
    logic   do_write;
    logic   do_read;

    assign o_empty  = (count == '0);
    assign o_full   = (count == count_t'(DEPTH));
    assign do_write = i_write && !o_full;
    assign do_read  = i_read && !o_empty;

    // First word fall through
    assign o_data = mem[read_ptr];

    always_ff @(posedge i_clock or posedge i_reset) begin
        if (i_reset) begin
            read_ptr  <= '0;
            write_ptr <= '0;
            count     <= '0;
        end else begin
            if (do_write) begin
                write_ptr <= (write_ptr == ptr_t'(DEPTH - 1)) ? '0 : write_ptr + 1'b1;
            end
            if (do_read) begin
                read_ptr <= (read_ptr == ptr_t'(DEPTH - 1)) ? '0 : read_ptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge i_clock) begin
        if (do_write) begin
            mem[write_ptr] <= i_data;
        end
    end

endmodule

/* design/uart_alu_pkg.sv */
package uart_alu_pkg;

    // Byte and opcode widths
    localparam int DATA_WIDTH   = 8;
    localparam int OPCODE_WIDTH = 6;

    // Serial bit timing in clocks
    localparam int CLKS_PER_BIT    = 16;
    localparam int HALF_BIT_CLKS   = CLKS_PER_BIT / 2;
    localparam int CLK_COUNT_WIDTH = $clog2(CLKS_PER_BIT);

    // Entries per FIFO
    localparam int FIFO_DEPTH = 8;

    typedef logic [DATA_WIDTH-1:0]         data_t;
    typedef logic [OPCODE_WIDTH-1:0]       opcode_t;
    typedef logic [CLK_COUNT_WIDTH-1:0]    clk_count_t;
    typedef logic [$clog2(DATA_WIDTH)-1:0] bit_index_t;

    // Codes follow the MIPS function field
    typedef enum opcode_t {
        ADD = 6'b100000,
        SUB = 6'b100010,
        AND = 6'b100100,
        OR  = 6'b100101,
        XOR = 6'b100110,
        NOR = 6'b100111,
        SRL = 6'b000010,
        SRA = 6'b000011
    } alu_op_e;

    typedef struct packed {
        opcode_t opcode;
        data_t   operand_a;
        data_t   operand_b;
    } alu_command_t;

    typedef enum logic [1:0] {
        GET_OPCODE,
        GET_OPERAND_A,
        GET_OPERAND_B,
        WRITE_RESULT
    } seq_state_e;

endpackage

/* design/uart_alu_top.sv */
`timescale 1ns/1ns

module uart_alu_top import uart_alu_pkg::*; (
    input  logic i_clock,
    input  logic i_reset,
    input  logic i_rx_serial,
    output logic o_tx_serial
);

    data_t        rx_byte;
    logic         rx_byte_valid;
    data_t        rx_fifo_data;
    logic         rx_fifo_empty;
    logic         rx_fifo_read;
    alu_command_t command;
    data_t        alu_result;
    data_t        tx_fifo_wdata;
    logic         tx_fifo_write;
    logic         tx_fifo_full;
    data_t        tx_fifo_data;
    logic         tx_fifo_empty;
    logic         tx_fifo_read;

    ////////////////////////////////////////////////////////////////////////////
    // Receive path
    ////////////////////////////////////////////////////////////////////////////

    uart_rx uart_rx_inst (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_serial     (i_rx_serial),
        .o_data       (rx_byte),
        .o_data_valid (rx_byte_valid)
    );

    // Bytes arriving while full are dropped inside the FIFO
    byte_fifo rx_fifo (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .i_write (rx_byte_valid),
        .i_data  (rx_byte),
        .i_read  (rx_fifo_read),
        .o_data  (rx_fifo_data),
        .o_empty (rx_fifo_empty),
        .o_full  ()
    );

    ////////////////////////////////////////////////////////////////////////////
    // Command and compute
    ////////////////////////////////////////////////////////////////////////////

    alu_command_sequencer alu_command_sequencer_inst (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .i_rx_data  (rx_fifo_data),
        .i_rx_empty (rx_fifo_empty),
        .o_rx_read  (rx_fifo_read),
        .o_command  (command),
        .i_result   (alu_result),
        .i_tx_full  (tx_fifo_full),
        .o_tx_data  (tx_fifo_wdata),
        .o_tx_write (tx_fifo_write)
    );

    alu alu_inst (
        .i_command (command),
        .o_result  (alu_result)
    );

    // Transmit path
    byte_fifo tx_fifo (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .i_write (tx_fifo_write),
        .i_data  (tx_fifo_wdata),
        .i_read  (tx_fifo_read),
        .o_data  (tx_fifo_data),
        .o_empty (tx_fifo_empty),
        .o_full  (tx_fifo_full)
    );

    uart_tx uart_tx_inst (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_fifo_empty (tx_fifo_empty),
        .i_data       (tx_fifo_data),
        .o_read       (tx_fifo_read),
        .o_serial     (o_tx_serial)
    );

endmodule

/* design/uart_rx.sv */
`timescale 1ns/1ns

module uart_rx import uart_alu_pkg::*; (
    input  logic  i_clock,
    input  logic  i_reset,
    input  logic  i_serial,
    output data_t o_data,
    output logic  o_data_valid
);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    rx_state_e  state;
    logic [1:0] serial_sync;
    logic       serial_prev;
    clk_count_t clock_count;
    bit_index_t bit_index;
    data_t      shift_data;
    logic       bit_sample;

    // Two flop synchronizer plus one stage for the falling edge
    always_ff @(posedge i_clock or posedge i_reset) begin
        if (i_reset) begin
            serial_sync <= 2'b11;
            serial_prev <= 1'b1;
        end else begin
            serial_sync <= {serial_sync[0], i_serial};
            serial_prev <= serial_sync[1];
        end
    end

    // Counter is realigned at mid start bit, so every wrap lands mid-bit
    assign bit_sample = (clock_count == clk_count_t'(CLKS_PER_BIT - 1));

    always_ff @(posedge i_clock or posedge i_reset) begin
        if (i_reset) begin
            state        <= RX_IDLE;
            clock_count  <= '0;
            bit_index    <= '0;
            o_data_valid <= 1'b0;
        end else begin
            o_data_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    clock_count <= '0;
                    bit_index   <= '0;
                    if (serial_prev && !serial_sync[1]) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (clock_count == clk_count_t'(HALF_BIT_CLKS - 1)) begin
                        clock_count <= '0;
                        // Line back high at mid-bit means a glitch
                        state <= serial_sync[1] ? RX_IDLE : RX_DATA;
                    end else begin
                        clock_count <= clock_count + 1'b1;
                    end
                end
                RX_DATA: begin
                    clock_count <= clock_count + 1'b1;
                    if (bit_sample) begin
                        bit_index <= bit_index + 1'b1;
                        if (bit_index == bit_index_t'(DATA_WIDTH - 1)) begin
                            state <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    clock_count <= clock_count + 1'b1;
                    if (bit_sample) begin
                        // Bad stop bit drops the byte
                        o_data_valid <= serial_sync[1];
                        state        <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // LSB arrives first, so shift in from the top
    always_ff @(posedge i_clock) begin
        if (state == RX_DATA && bit_sample) begin
            shift_data <= {serial_sync[1], shift_data[DATA_WIDTH-1:1]};
        end
    end

    assign o_data = shift_data;

endmodule

/* design/uart_tx.sv */
`timescale 1ns/1ns

module uart_tx import uart_alu_pkg::*; (
    input  logic  i_clock,
    input  logic  i_reset,
    input  logic  i_fifo_empty,
    input  data_t i_data,
    output logic  o_read,
    output logic  o_serial
);

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_e;

    tx_state_e  state;
    clk_count_t clock_count;
    bit_index_t bit_index;
    data_t      shift_data;
    logic       bit_end;
    logic       frame_end;

    assign bit_end   = (clock_count == clk_count_t'(CLKS_PER_BIT - 1));
    assign frame_end = (state == TX_STOP) && bit_end;

    // Pop when idle, or at the last stop clock for back to back frames
    assign o_read = !i_fifo_empty && ((state == TX_IDLE) || frame_end);

    always_ff @(posedge i_clock or posedge i_reset) begin
        if (i_reset) begin
            state       <= TX_IDLE;
            clock_count <= '0;
            bit_index   <= '0;
        end else begin
            clock_count <= (state == TX_IDLE || bit_end) ? '0 : clock_count + 1'b1;
            case (state)
                TX_IDLE: begin
                    if (o_read) begin
                        state <= TX_START;
                    end
                end
                TX_START: begin
                    bit_index <= '0;
                    if (bit_end) begin
                        state <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        bit_index <= bit_index + 1'b1;
                        if (bit_index == bit_index_t'(DATA_WIDTH - 1)) begin
                            state <= TX_STOP;
                        end
                    end
                end
                TX_STOP: begin
                    if (bit_end) begin
                        state <= o_read ? TX_START : TX_IDLE;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clock) begin
        if (o_read) begin
            shift_data <= i_data;
        end else if (state == TX_DATA && bit_end) begin
            shift_data <= shift_data >> 1;
        end
    end

    always_comb begin
        case (state)
            TX_START: o_serial = 1'b0;
            TX_DATA:  o_serial = shift_data[0];
            default:  o_serial = 1'b1;
        endcase
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, and check the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module uart_alu_top_tb \
    -f uart_alu_top.f -o uart_alu_sim

./obj_dir/uart_alu_sim > sim.log 2>&1
cat sim.log

if grep -q "RESULT: PASS" sim.log; then
    exit 0
fi
exit 1

/* uart_alu_top.f */
+incdir+verification
design/uart_alu_pkg.sv
design/uart_rx.sv
design/uart_tx.sv
design/byte_fifo.sv
design/alu_command_sequencer.sv
design/alu.sv
design/uart_alu_top.sv
verification/uart_alu_top_tb.sv

/* verification/uart_alu_serial_tasks.svh */
`ifndef UART_ALU_SERIAL_TASKS_SVH
`define UART_ALU_SERIAL_TASKS_SVH

////////////////////////////////////////////////////////////////////////////
// Serial line drive and capture
////////////////////////////////////////////////////////////////////////////

// Called at the drive point, returns at the next drive point
task automatic drive_bit(input logic level);
    rx_serial = level;
    repeat (CLKS_PER_BIT) @(posedge clock);
    #DRIVE_DELAY;
endtask

// Start bit, eight data bits LSB first, stop bit
task automatic send_frame(input data_t value);
    int n;
    drive_bit(1'b0);
    for (n = 0; n < DATA_WIDTH; n++) begin
        drive_bit(value[0]);
        value = value >> 1;
    end
    drive_bit(1'b1);
endtask

// Samples on the falling clock edge, away from the DUT's output changes
task automatic capture_frame(input int limit, output data_t value, output bit timed_out,
                             output bit framing_ok);
    int   waited;
    int   n;
    logic start_level;
    timed_out  = 1'b0;
    framing_ok = 1'b0;
    value      = '0;
    waited     = 0;
    @(negedge clock);
    while (tx_serial !== 1'b0 && waited < limit) begin
        @(negedge clock);
        waited++;
    end
    if (tx_serial !== 1'b0) begin
        timed_out = 1'b1;
    end else begin
        // Middle of the start bit
        repeat (HALF_BIT_CLKS) @(negedge clock);
        start_level = tx_serial;
        for (n = 0; n < DATA_WIDTH; n++) begin
            repeat (CLKS_PER_BIT) @(negedge clock);
            value = {tx_serial, value[DATA_WIDTH-1:1]};
        end
        repeat (CLKS_PER_BIT) @(negedge clock);
        framing_ok = (start_level === 1'b0) && (tx_serial === 1'b1);
    end
endtask

////////////////////////////////////////////////////////////////////////////
// Compare tasks
////////////////////////////////////////////////////////////////////////////

task automatic check_result(input string name, input data_t expected, input data_t actual);
    if (actual === expected) begin
        pass_count++;
        $display("Passed   %-18s result 0x%02h", name, actual);
    end else begin
        fail_count++;
        $display("Mismatch %s: expected 0x%02h, actual 0x%02h", name, expected, actual);
    end
endtask

task automatic check_idle(input string name, input int clocks);
    int n;
    bit went_low;
    went_low = 1'b0;
    for (n = 0; n < clocks; n++) begin
        @(negedge clock);
        if (tx_serial !== 1'b1) begin
            went_low = 1'b1;
        end
    end
    if (went_low) begin
        fail_count++;
        $display("Error in %s: o_tx_serial left idle with no command sent", name);
    end else begin
        pass_count++;
        $display("Passed   %-18s line idle for %0d clocks", name, clocks);
    end
endtask

`endif

/* verification/uart_alu_top_tb.sv */
`timescale 1ns/1ns

module uart_alu_top_tb import uart_alu_pkg::*; ();

    localparam int CLOCK_PERIOD    = 20;
    localparam int DRIVE_DELAY     = 2;
    localparam int RESET_CYCLES    = 5;
    localparam int NUM_FIXED       = 16;
    localparam int NUM_RANDOM      = 4;
    localparam int NUM_TESTS       = NUM_FIXED + NUM_RANDOM;
    localparam int BITS_PER_TEST   = 40;
    localparam int WATCHDOG_MARGIN = 2;
    localparam int WATCHDOG_NS     = WATCHDOG_MARGIN * NUM_TESTS * BITS_PER_TEST
                                     * CLKS_PER_BIT * CLOCK_PERIOD;

    typedef struct packed {
        data_t opcode_byte;
        data_t operand_a;
        data_t operand_b;
        data_t expected;
    } test_vector_t;

    logic         clock;
    logic         reset;
    logic         rx_serial;
    logic         tx_serial;
    test_vector_t vectors [NUM_TESTS];
    string        names [NUM_TESTS];
    int           seed;
    int           pass_count;
    int           fail_count;

    uart_alu_top uart_alu_top_inst (
        .i_clock     (clock),
        .i_reset     (reset),
        .i_rx_serial (rx_serial),
        .o_tx_serial (tx_serial)
    );

    `include "uart_alu_serial_tasks.svh"

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    // Result of one command, worked out from the operation rules
    function automatic data_t expected_result(input data_t opcode_byte, input data_t a,
                                              input data_t b);
        opcode_t          code;
        bit_index_t       shift;
        logic [DATA_WIDTH:0] sum;
        data_t            value;
        code  = opcode_byte[OPCODE_WIDTH-1:0];
        shift = b[$bits(bit_index_t)-1:0];
        sum   = {1'b0, a} + {1'b0, b};
        case (code)
            ADD:     value = sum[DATA_WIDTH-1:0];
            SUB:     value = a + (~b + 1'b1);
            AND:     value = a & b;
            OR:      value = a | b;
            XOR:     value = a ^ b;
            NOR:     value = ~(a | b);
            SRL:     value = a >> shift;
            // Vacated top bits take the sign of A
            SRA:     value = (a >> shift) | (a[DATA_WIDTH-1] ? ~({DATA_WIDTH{1'b1}} >> shift) : '0);
            default: value = '0;
        endcase
        return value;
    endfunction

    task automatic set_entry(input int index, input string name, input data_t opcode_byte,
                             input data_t a, input data_t b, input data_t expected);
        names[index]   = name;
        vectors[index] = {opcode_byte, a, b, expected};
    endtask

    task automatic build_table();
        data_t random_ops [NUM_RANDOM];
        string random_names [NUM_RANDOM];
        data_t a;
        data_t b;
        int    n;
        set_entry(0,  "add_basic",       8'h20, 8'h12, 8'h34, 8'h46);
        set_entry(1,  "add_wrap",        8'h20, 8'hF0, 8'h25, 8'h15);
        set_entry(2,  "sub_basic",       8'h22, 8'h50, 8'h13, 8'h3D);
        set_entry(3,  "sub_wrap",        8'h22, 8'h05, 8'h0A, 8'hFB);
        set_entry(4,  "and",             8'h24, 8'hCA, 8'h5F, 8'h4A);
        set_entry(5,  "or",              8'h25, 8'hCA, 8'h15, 8'hDF);
        set_entry(6,  "xor",             8'h26, 8'hFF, 8'h5A, 8'hA5);
        set_entry(7,  "nor",             8'h27, 8'h0F, 8'h30, 8'hC0);
        set_entry(8,  "srl",             8'h02, 8'h96, 8'h03, 8'h12);
        set_entry(9,  "srl_by_zero",     8'h02, 8'h96, 8'h00, 8'h96);
        set_entry(10, "srl_low_bits_b",  8'h02, 8'hF0, 8'h0C, 8'h0F);
        set_entry(11, "sra_negative",    8'h03, 8'h96, 8'h02, 8'hE5);
        set_entry(12, "sra_positive",    8'h03, 8'h74, 8'h04, 8'h07);
        set_entry(13, "sra_by_seven",    8'h03, 8'h80, 8'h0F, 8'hFF);
        set_entry(14, "unknown_opcode",  8'h3F, 8'h12, 8'h34, 8'h00);
        set_entry(15, "opcode_top_bits", 8'hE0, 8'h12, 8'h34, 8'h46);
        // These four go out back to back
        random_ops[0]   = 8'h20;
        random_ops[1]   = 8'h22;
        random_ops[2]   = 8'h26;
        random_ops[3]   = 8'h03;
        random_names[0] = "rand_add";
        random_names[1] = "rand_sub";
        random_names[2] = "rand_xor";
        random_names[3] = "rand_sra";
        for (n = 0; n < NUM_RANDOM; n++) begin
            a = data_t'($random(seed));
            b = data_t'($random(seed));
            set_entry(NUM_FIXED + n, random_names[n], random_ops[n], a, b,
                      expected_result(random_ops[n], a, b));
        end
    endtask

    task automatic send_command(input test_vector_t vector);
        send_frame(vector.opcode_byte);
        send_frame(vector.operand_a);
        send_frame(vector.operand_b);
    endtask

    // Sends count commands with no gap and collects their results in order
    task automatic run_group(input int first, input int count);
        int    k_send;
        int    k_recv;
        int    limit;
        data_t actual;
        bit    timed_out;
        bit    framing_ok;
        limit = (30 * count + 20) * CLKS_PER_BIT;
        fork
            begin
                @(posedge clock);
                #DRIVE_DELAY;
                for (k_send = 0; k_send < count; k_send++) begin
                    send_command(vectors[first + k_send]);
                end
            end
            begin
                for (k_recv = 0; k_recv < count; k_recv++) begin
                    capture_frame(limit, actual, timed_out, framing_ok);
                    if (timed_out) begin
                        fail_count++;
                        $display("Error in %s: no result frame on o_tx_serial within %0d clocks",
                                 names[first + k_recv], limit);
                    end else if (!framing_ok) begin
                        fail_count++;
                        $display("Error in %s: result frame has a bad start or stop bit",
                                 names[first + k_recv]);
                    end else begin
                        check_result(names[first + k_recv], vectors[first + k_recv].expected,
                                     actual);
                    end
                end
            end
        join
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        int n;
        rx_serial  = 1'b1;
        reset      = 1'b1;
        seed       = 32'h0be62d7e;
        pass_count = 0;
        fail_count = 0;
        build_table();
        repeat (RESET_CYCLES) @(posedge clock);
        #DRIVE_DELAY;
        reset = 1'b0;

        check_idle("idle_after_reset", BITS_PER_TEST * CLKS_PER_BIT);
        for (n = 0; n < NUM_FIXED; n++) begin
            run_group(n, 1);
        end
        run_group(NUM_FIXED, NUM_RANDOM);

        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
